/* include/experiar_video_macros.svh */
`ifndef EXPERIAR_VIDEO_MACROS_SVH
`define EXPERIAR_VIDEO_MACROS_SVH

// Wishbone slave side
`define WB_DATA_WIDTH 32
`define WB_SEL_WIDTH 4
`define WB_ADR_WIDTH 24

// Frame buffer banks, 512 words each
`define SRAM_ADDRESS_SIZE 9
`define FB_BANKS 4
`define FB_BANK_SEL_WIDTH 2

// Stored picture, one byte per element
`define FB_COLS 80
`define FB_ROWS 60
`define PIXEL_SCALE_LOG2 3

// Horizontal timing in clocks
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_BACK 48

// Vertical timing in lines
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_BACK 33

`endif

/* verilog/experiar_video_pkg.sv */
`default_nettype none

`include "experiar_video_macros.svh"

package experiar_video_pkg;

	// Master to slave
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`WB_SEL_WIDTH-1:0] sel;
		logic [`WB_ADR_WIDTH-1:0] adr;
		logic [`WB_DATA_WIDTH-1:0] data;
	} wb_req_t;

	// Slave back to master
	typedef struct packed {
		logic ack;
		logic [`WB_DATA_WIDTH-1:0] data;
	} wb_rsp_t;

	// Read-write port of the frame buffer
	typedef struct packed {
		logic en;
		logic we;
		logic [`WB_SEL_WIDTH-1:0] wmask;
		logic [`FB_BANK_SEL_WIDTH-1:0] bank;
		logic [`SRAM_ADDRESS_SIZE-1:0] addr;
		logic [`WB_DATA_WIDTH-1:0] din;
	} fb_rw_req_t;

	// Read-only port, used by scanout
	typedef struct packed {
		logic en;
		logic [`FB_BANK_SEL_WIDTH-1:0] bank;
		logic [`SRAM_ADDRESS_SIZE-1:0] addr;
	} fb_rd_req_t;

	// Matches bits 5:0 of a stored byte
	typedef struct packed {
		logic [1:0] r;
		logic [1:0] g;
		logic [1:0] b;
	} pixel_t;

endpackage

`default_nettype wire

/* verilog/sram_bank.sv */
`timescale 1ns/10ps
`default_nettype none

`include "experiar_video_macros.svh"

module sram_bank (
		input wire logic wb_clk_i,

		// Port 0, read or byte-masked write
		input wire logic en0_i,
		input wire logic we0_i,
		input wire logic [`WB_SEL_WIDTH-1:0] wmask0_i,
		input wire logic [`SRAM_ADDRESS_SIZE-1:0] addr0_i,
		input wire logic [`WB_DATA_WIDTH-1:0] din0_i,
		output logic [`WB_DATA_WIDTH-1:0] dout0_o,

		// Port 1, read only
		input wire logic en1_i,
		input wire logic [`SRAM_ADDRESS_SIZE-1:0] addr1_i,
		output logic [`WB_DATA_WIDTH-1:0] dout1_o
	);

	localparam int DEPTH = 1 << `SRAM_ADDRESS_SIZE;

	logic [`WB_DATA_WIDTH-1:0] mem [DEPTH];

	always_ff @(posedge wb_clk_i) begin
		if (en0_i) begin
			if (we0_i) begin
				for (int i = 0; i < `WB_SEL_WIDTH; i++) begin
					if (wmask0_i[i]) mem[addr0_i][i*8 +: 8] <= din0_i[i*8 +: 8];
				end
			end else begin
				dout0_o <= mem[addr0_i];
			end
		end
	end

	// Same-cycle write on port 0 is not seen here
	always_ff @(posedge wb_clk_i) begin
		if (en1_i) dout1_o <= mem[addr1_i];
	end

endmodule

`default_nettype wire

/* verilog/video_frame_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "experiar_video_macros.svh"

module video_frame_buffer (
		input wire logic wb_clk_i,

		// Bus side, read-write
		input wire experiar_video_pkg::fb_rw_req_t rw_req_i,
		output logic [`WB_DATA_WIDTH-1:0] rw_data_o,

		// Scanout side, read only
		input wire experiar_video_pkg::fb_rd_req_t rd_req_i,
		output logic [`WB_DATA_WIDTH-1:0] rd_data_o
	);

	logic [`FB_BANKS-1:0] rw_en;
	logic [`FB_BANKS-1:0] rd_en;
	logic [`WB_DATA_WIDTH-1:0] rw_dout [`FB_BANKS];
	logic [`WB_DATA_WIDTH-1:0] rd_dout [`FB_BANKS];
	logic [`FB_BANK_SEL_WIDTH-1:0] rw_bank_q;
	logic [`FB_BANK_SEL_WIDTH-1:0] rd_bank_q;

	// One-hot bank enables
	assign rw_en = rw_req_i.en ? `FB_BANKS'(1) << rw_req_i.bank : '0;
	assign rd_en = rd_req_i.en ? `FB_BANKS'(1) << rd_req_i.bank : '0;

	genvar b;
	generate
		for (b = 0; b < `FB_BANKS; b++) begin : g_bank
			sram_bank bank (
				.wb_clk_i(wb_clk_i),
				.en0_i(rw_en[b]),
				.we0_i(rw_req_i.we),
				.wmask0_i(rw_req_i.wmask),
				.addr0_i(rw_req_i.addr),
				.din0_i(rw_req_i.din),
				.dout0_o(rw_dout[b]),
				.en1_i(rd_en[b]),
				.addr1_i(rd_req_i.addr),
				.dout1_o(rd_dout[b]));
		end
	endgenerate

	// Remember which bank answers next cycle
	always_ff @(posedge wb_clk_i) begin
		if (rw_req_i.en) rw_bank_q <= rw_req_i.bank;
		if (rd_req_i.en) rd_bank_q <= rd_req_i.bank;
	end

	assign rw_data_o = rw_dout[rw_bank_q];
	assign rd_data_o = rd_dout[rd_bank_q];

endmodule

`default_nettype wire

/* verilog/video_wb_port.sv */
`timescale 1ns/10ps
`default_nettype none

`include "experiar_video_macros.svh"

module video_wb_port (
		input wire logic wb_clk_i,
		input wire logic rst_i,

		// Bus side
		input wire experiar_video_pkg::wb_req_t wb_req_i,
		output experiar_video_pkg::wb_rsp_t wb_rsp_o,

		// Frame buffer read-write port
		output experiar_video_pkg::fb_rw_req_t fb_req_o,
		input wire logic [`WB_DATA_WIDTH-1:0] fb_data_i
	);

	logic request;
	logic ack_q;

	assign request = wb_req_i.cyc && wb_req_i.stb;

	// Word address split, bits above the bank field are ignored
	always_comb begin
		fb_req_o.en = request;
		fb_req_o.we = wb_req_i.we;
		fb_req_o.wmask = wb_req_i.we ? wb_req_i.sel : '0;	// Reads touch no bytes
		fb_req_o.bank = wb_req_i.adr[`SRAM_ADDRESS_SIZE +: `FB_BANK_SEL_WIDTH];
		fb_req_o.addr = wb_req_i.adr[`SRAM_ADDRESS_SIZE-1:0];
		fb_req_o.din = wb_req_i.data;
	end

	// One ack per request, no wait states
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= request;
		end
	end

	// Bank read data arrives in the ack cycle
	always_comb begin
		wb_rsp_o.ack = ack_q;
		wb_rsp_o.data = fb_data_i;
	end

endmodule

`default_nettype wire

/* verilog/vga_scanout.sv */
`timescale 1ns/10ps
`default_nettype none

`include "experiar_video_macros.svh"

module vga_scanout (
		input wire logic wb_clk_i,
		input wire logic rst_i,

		// Frame buffer read port
		output experiar_video_pkg::fb_rd_req_t rd_req_o,
		input wire logic [`WB_DATA_WIDTH-1:0] rd_data_i,

		// VGA pins
		output experiar_video_pkg::pixel_t pixel_o,
		output logic hsync_o,
		output logic vsync_o
	);

	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
	localparam int H_SYNC_START = `H_ACTIVE + `H_FRONT;
	localparam int V_SYNC_START = `V_ACTIVE + `V_FRONT;
	localparam int H_W = $clog2(H_TOTAL);
	localparam int V_W = $clog2(V_TOTAL);
	localparam int ELEM_W = $clog2(`FB_COLS * `FB_ROWS);
	localparam int WORD_W = `FB_BANK_SEL_WIDTH + `SRAM_ADDRESS_SIZE;
	localparam int LANE_W = $clog2(`WB_SEL_WIDTH);

	logic [H_W-1:0] h_count;
	logic [V_W-1:0] v_count;
	logic [H_W-`PIXEL_SCALE_LOG2-1:0] col;
	logic [V_W-`PIXEL_SCALE_LOG2-1:0] row;
	logic [ELEM_W-1:0] elem_index;
	logic [WORD_W-1:0] word_index;
	logic active;
	logic hsync_n;
	logic vsync_n;

	// First stage, lines up with the bank read
	logic [LANE_W-1:0] lane_q;
	logic active_q;
	logic hsync_q;
	logic vsync_q;
	logic [5:0] pixel_bits;

	// Position counters, line first then frame
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			h_count <= '0;
			v_count <= '0;
		end else if (h_count == H_W'(H_TOTAL - 1)) begin
			h_count <= '0;
			if (v_count == V_W'(V_TOTAL - 1)) begin
				v_count <= '0;
			end else begin
				v_count <= v_count + 1'b1;
			end
		end else begin
			h_count <= h_count + 1'b1;
		end
	end

	assign active = (h_count < H_W'(`H_ACTIVE)) && (v_count < V_W'(`V_ACTIVE));
	assign hsync_n = !((h_count >= H_W'(H_SYNC_START))
		&& (h_count < H_W'(H_SYNC_START + `H_SYNC)));
	assign vsync_n = !((v_count >= V_W'(V_SYNC_START))
		&& (v_count < V_W'(V_SYNC_START + `V_SYNC)));

	// Each stored element covers an 8 by 8 block
	assign col = h_count[H_W-1:`PIXEL_SCALE_LOG2];
	assign row = v_count[V_W-1:`PIXEL_SCALE_LOG2];
	assign elem_index = ELEM_W'(row) * ELEM_W'(`FB_COLS) + ELEM_W'(col);
	assign word_index = WORD_W'(elem_index >> LANE_W);	// Four elements per word

	// One fetch per active clock
	always_comb begin
		rd_req_o.en = active;
		rd_req_o.bank = word_index[WORD_W-1 -: `FB_BANK_SEL_WIDTH];
		rd_req_o.addr = word_index[`SRAM_ADDRESS_SIZE-1:0];
	end

	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			active_q <= 1'b0;
			hsync_q <= 1'b1;
			vsync_q <= 1'b1;
		end else begin
			active_q <= active;
			hsync_q <= hsync_n;
			vsync_q <= vsync_n;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		lane_q <= elem_index[LANE_W-1:0];	// Lane 0 is the low byte
	end

	// Top two bits of the byte are unused
	assign pixel_bits = rd_data_i[{lane_q, 3'b000} +: 6];

	// Output stage, blanked outside the picture
	always_ff @(posedge wb_clk_i) begin
		if (rst_i) begin
			pixel_o <= '0;
			hsync_o <= 1'b1;
			vsync_o <= 1'b1;
		end else begin
			pixel_o <= active_q ? experiar_video_pkg::pixel_t'(pixel_bits) : '0;
			hsync_o <= hsync_q;
			vsync_o <= vsync_q;
		end
	end

endmodule

`default_nettype wire

/* verilog/experiar_video.sv */
`timescale 1ns/10ps
`default_nettype none

`include "experiar_video_macros.svh"

module experiar_video (
		input wire logic wb_clk_i,
		input wire logic rst_i,

		// Wishbone slave
		input wire experiar_video_pkg::wb_req_t wb_req_i,
		output experiar_video_pkg::wb_rsp_t wb_rsp_o,

		// VGA
		output experiar_video_pkg::pixel_t vga_pixel_o,
		output logic vga_hsync_o,
		output logic vga_vsync_o
	);

	experiar_video_pkg::fb_rw_req_t fb_rw_req;
	experiar_video_pkg::fb_rd_req_t fb_rd_req;
	logic [`WB_DATA_WIDTH-1:0] fb_rw_data;
	logic [`WB_DATA_WIDTH-1:0] fb_rd_data;

	video_wb_port wb_port (
		.wb_clk_i(wb_clk_i),
		.rst_i(rst_i),
		.wb_req_i(wb_req_i),
		.wb_rsp_o(wb_rsp_o),
		.fb_req_o(fb_rw_req),
		.fb_data_i(fb_rw_data));

	video_frame_buffer frame_buffer (
		.wb_clk_i(wb_clk_i),
		.rw_req_i(fb_rw_req),
		.rw_data_o(fb_rw_data),
		.rd_req_i(fb_rd_req),
		.rd_data_o(fb_rd_data));

	// Scanout runs straight off the bus clock
	vga_scanout scanout (
		.wb_clk_i(wb_clk_i),
		.rst_i(rst_i),
		.rd_req_o(fb_rd_req),
		.rd_data_i(fb_rd_data),
		.pixel_o(vga_pixel_o),
		.hsync_o(vga_hsync_o),
		.vsync_o(vga_vsync_o));

endmodule

`default_nettype wire

/* dv/experiar_video_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "experiar_video_macros.svh"

module experiar_video_tb;

	localparam int TIMEOUT_CYCLES = 1_000_000;	// Two frames plus bus traffic
	localparam int BUS_WORDS = 16;
	localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
	localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

	logic wb_clk_i;
	logic rst_i;
	experiar_video_pkg::wb_req_t wb_req;
	experiar_video_pkg::wb_rsp_t wb_rsp;
	experiar_video_pkg::pixel_t vga_pixel;
	logic vga_hsync;
	logic vga_vsync;

	logic [31:0] ref_mem [2048];	// Flat word index, bank in bits 10:9
	logic [23:0] bus_adr [BUS_WORDS];
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;

	experiar_video dut_i (
		.wb_clk_i(wb_clk_i),
		.rst_i(rst_i),
		.wb_req_i(wb_req),
		.wb_rsp_o(wb_rsp),
		.vga_pixel_o(vga_pixel),
		.vga_hsync_o(vga_hsync),
		.vga_vsync_o(vga_vsync));

	initial begin
		wb_clk_i = 1'b0;
		forever #2 wb_clk_i = ~wb_clk_i;
	end

	always @(posedge wb_clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout, run stopped after %0d cycles", cycle_count);
			$display("Checks: %0d, errors: %0d", checks, errors);
			$display("Errors found");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, exp);
		end
	endtask

	function automatic experiar_video_pkg::wb_req_t make_req(input logic we,
			input logic [23:0] adr, input logic [3:0] sel, input logic [31:0] data);
		experiar_video_pkg::wb_req_t req;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = sel;
		req.adr = adr;
		req.data = data;
		return req;
	endfunction

	// Single write, ack expected exactly one cycle later
	task automatic bus_write(input logic [23:0] adr, input logic [3:0] sel,
			input logic [31:0] data);
		@(posedge wb_clk_i);
		wb_req <= make_req(1'b1, adr, sel, data);
		@(negedge wb_clk_i);
		check_value("wb_rsp.ack", wb_rsp.ack, 1'b0);
		@(posedge wb_clk_i);
		wb_req <= '0;
		@(negedge wb_clk_i);
		check_value("wb_rsp.ack", wb_rsp.ack, 1'b1);
		for (int b = 0; b < 4; b++) begin
			if (sel[b]) ref_mem[adr[10:0]][b*8 +: 8] = data[b*8 +: 8];
		end
	endtask

	// Back-to-back reads, each ack lands while the next request is out
	task automatic read_back;
		for (int i = 0; i <= BUS_WORDS; i++) begin
			@(posedge wb_clk_i);
			if (i < BUS_WORDS) wb_req <= make_req(1'b0, bus_adr[i], 4'h0, $urandom());
			else wb_req <= '0;
			@(negedge wb_clk_i);
			check_value("wb_rsp.ack", wb_rsp.ack, i > 0);
			if (i > 0) begin
				check_value("wb_rsp.data", wb_rsp.data, ref_mem[bus_adr[i-1][10:0]]);
			end
		end
	endtask

	task automatic bus_write_read;
		for (int i = 0; i < BUS_WORDS; i++) begin
			bus_adr[i] = {13'($urandom()), 2'(i % 4), 9'((i * 37) % 512)};
			bus_write(bus_adr[i], 4'hf, $urandom());
			bus_write(bus_adr[i], 4'(i), $urandom());	// Every mask pattern once
		end
		read_back();
	endtask

	// Starts and ends on a falling clock edge
	task automatic wait_sync_edge(input bit vertical, input logic level);
		logic prev;
		logic now;
		now = vertical ? vga_vsync : vga_hsync;
		do begin
			prev = now;
			@(negedge wb_clk_i);
			now = vertical ? vga_vsync : vga_hsync;
		end while (!(now === level && prev !== level));
	endtask

	task automatic sync_timing(input bit vertical, input int low_exp, input int period_exp);
		int low;
		int period;
		low = 0;
		period = 0;
		wait_sync_edge(vertical, 1'b0);
		while ((vertical ? vga_vsync : vga_hsync) === 1'b0) begin
			low++;
			period++;
			@(negedge wb_clk_i);
		end
		while ((vertical ? vga_vsync : vga_hsync) === 1'b1) begin
			period++;
			@(negedge wb_clk_i);
		end
		check_value(vertical ? "vsync low cycles" : "hsync low cycles", low, low_exp);
		check_value(vertical ? "vsync period" : "hsync period", period, period_exp);
	endtask

	function automatic logic [5:0] expected_pixel(input int x, input int y);
		int elem;
		elem = (y >> `PIXEL_SCALE_LOG2) * `FB_COLS + (x >> `PIXEL_SCALE_LOG2);
		return ref_mem[elem / 4][(elem % 4) * 8 +: 6];
	endfunction

	task automatic check_line(input int y);
		logic [5:0] exp;
		for (int c = 0; c < H_TOTAL; c++) begin
			exp = 6'h0;
			if (y >= 0 && c >= `H_BACK && c < `H_BACK + `H_ACTIVE) begin
				exp = expected_pixel(c - `H_BACK, y);
			end
			check_value("vga_pixel_o", vga_pixel, exp);
			if (c < H_TOTAL - 1) @(negedge wb_clk_i);
		end
	endtask

	task automatic picture_content;
		while (vga_vsync !== 1'b0) @(negedge wb_clk_i);	// Fill during vertical blanking
		for (int w = 0; w < 2 * `FB_COLS / 4; w++) begin
			bus_write(24'(w), 4'hf, $urandom());
		end
		wait_sync_edge(1'b1, 1'b1);
		// The back porch lines come first, blank
		for (int n = 1; n <= `V_BACK + 15; n++) begin
			wait_sync_edge(1'b0, 1'b1);
			check_line(n - `V_BACK);
		end
	endtask

	initial begin
		void'($urandom(32'h10c4b5b0));
		rst_i = 1'b1;
		wb_req = '0;
		repeat (4) @(posedge wb_clk_i);
		@(negedge wb_clk_i);
		check_value("wb_rsp.ack", wb_rsp.ack, 1'b0);
		check_value("vga_pixel_o", vga_pixel, 6'h0);
		check_value("vga_hsync_o", vga_hsync, 1'b1);
		check_value("vga_vsync_o", vga_vsync, 1'b1);
		@(posedge wb_clk_i);
		rst_i <= 1'b0;
		bus_write_read();
		sync_timing(1'b0, `H_SYNC, H_TOTAL);
		sync_timing(1'b1, `V_SYNC * H_TOTAL, V_TOTAL * H_TOTAL);
		picture_content();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* experiar_video.f */
+incdir+include
verilog/experiar_video_pkg.sv
verilog/sram_bank.sv
verilog/video_frame_buffer.sv
verilog/video_wb_port.sv
verilog/vga_scanout.sv
verilog/experiar_video.sv
dv/experiar_video_tb.sv
